// ==== sources.f ====
+incdir+tests
source/dlxPkg.sv
source/stageRegister.sv
source/registerFile.sv
source/controlDecoder.sv
source/operandSelect.sv
source/decodeStage.sv
tests/decodeStageTb.sv

// ==== Makefile ====
# Verilator flow for the decode stage testbench

TOP := decodeStageTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

# pass or fail comes from the simulation log
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== tests/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// shadow register file
//////////////////////////////////////////////////////////////////////

// architectural copy kept in step with the writeback bus
logic [0:31] shadowRegs [0:31];

// value decode sees for one read port in the current cycle
function automatic logic [0:31] shadowRead(
    input logic [0:4]         idx,
    input dlxPkg::writeback_t wbNow
);
    logic [0:31] value;
    value = shadowRegs[idx];
    if (idx == 5'd0) begin
        value = '0;
    end else if (wbNow.enable && wbNow.regIndex == idx) begin
        // a write in flight is visible to the read
        value = wbNow.data;
    end
    return value;
endfunction

// register update at the clock edge, r0 stays zero
function automatic void shadowWrite(input dlxPkg::writeback_t wbNow);
    if (wbNow.enable && wbNow.regIndex != 5'd0) begin
        shadowRegs[wbNow.regIndex] = wbNow.data;
    end
endfunction

//////////////////////////////////////////////////////////////////////
// expected control word
//////////////////////////////////////////////////////////////////////

function automatic dlxPkg::ctrlWord_t expectCtrl(input logic [0:31] instr);
    dlxPkg::ctrlWord_t c;
    logic [0:5]        op;
    logic [0:5]        fn;
    logic              isLoad;
    logic              isStore;
    logic              isBranch;
    logic              isAluImm;
    op       = instr[0:5];
    fn       = instr[26:31];
    c        = '0;
    isLoad   = op inside {dlxPkg::opLb, dlxPkg::opLh, dlxPkg::opLw,
                          dlxPkg::opLbu, dlxPkg::opLhu};
    isStore  = op inside {dlxPkg::opSb, dlxPkg::opSh, dlxPkg::opSw};
    isBranch = op inside {dlxPkg::opBeqz, dlxPkg::opBnez};
    isAluImm = op inside {dlxPkg::opAddi, dlxPkg::opSubi, dlxPkg::opAndi,
                          dlxPkg::opOri, dlxPkg::opXori, dlxPkg::opLhi};

    // signed offsets and arithmetic immediates
    c.extOp = isLoad || isStore || isBranch ||
              op == dlxPkg::opAddi || op == dlxPkg::opSubi;
    c.memToReg   = isLoad;
    c.memWrite   = isStore;
    c.loadSign   = isLoad && op != dlxPkg::opLbu && op != dlxPkg::opLhu;
    c.branch     = isBranch;
    c.branchZero = (op == dlxPkg::opBeqz);
    c.jump       = (op == dlxPkg::opJ) || (op == dlxPkg::opJal);
    c.regToPc    = (op == dlxPkg::opJr) || (op == dlxPkg::opJalr);
    c.pcToReg    = (op == dlxPkg::opJal) || (op == dlxPkg::opJalr);
    c.lhiOp      = (op == dlxPkg::opLhi);
    c.rType      = (op == dlxPkg::opRType);
    c.regWrite   = c.rType || isLoad || c.pcToReg || isAluImm;
    c.mul        = c.rType && fn == dlxPkg::fnMul;

    // access width only for memory ops
    if (op == dlxPkg::opLw || op == dlxPkg::opSw) begin
        c.dSize = dlxPkg::sizeWord;
    end else if (op inside {dlxPkg::opLh, dlxPkg::opLhu, dlxPkg::opSh}) begin
        c.dSize = dlxPkg::sizeHalf;
    end

    c.aluCtrl = dlxPkg::aluAdd;
    if (c.rType) begin
        case (fn)
            dlxPkg::fnSub: c.aluCtrl = dlxPkg::aluSub;
            dlxPkg::fnAnd: c.aluCtrl = dlxPkg::aluAnd;
            dlxPkg::fnOr:  c.aluCtrl = dlxPkg::aluOr;
            dlxPkg::fnXor: c.aluCtrl = dlxPkg::aluXor;
            dlxPkg::fnSll: c.aluCtrl = dlxPkg::aluSll;
            dlxPkg::fnSrl: c.aluCtrl = dlxPkg::aluSrl;
            dlxPkg::fnSra: c.aluCtrl = dlxPkg::aluSra;
            dlxPkg::fnSlt: c.aluCtrl = dlxPkg::aluSlt;
            dlxPkg::fnMul: c.aluCtrl = dlxPkg::aluPass;
            default:       c.aluCtrl = dlxPkg::aluAdd;
        endcase
    end else if (op == dlxPkg::opSubi) begin
        c.aluCtrl = dlxPkg::aluSub;
    end else if (op == dlxPkg::opAndi) begin
        c.aluCtrl = dlxPkg::aluAnd;
    end else if (op == dlxPkg::opOri) begin
        c.aluCtrl = dlxPkg::aluOr;
    end else if (op == dlxPkg::opXori) begin
        c.aluCtrl = dlxPkg::aluXor;
    end else if (c.lhiOp) begin
        c.aluCtrl = dlxPkg::aluSll;
    end
    return c;
endfunction

//////////////////////////////////////////////////////////////////////
// expected operands and full record
//////////////////////////////////////////////////////////////////////

function automatic dlxPkg::operands_t expectOps(
    input logic [0:31]       instr,
    input dlxPkg::ctrlWord_t c,
    input logic [0:31]       a,
    input logic [0:31]       b
);
    dlxPkg::operands_t o;
    logic [0:31]       imm;
    // negative immediates get the upper half filled when signed
    imm = 32'(instr[16:31]);
    if (c.extOp && instr[16]) begin
        imm = imm | 32'hFFFF0000;
    end
    o.imm16     = instr[16:31];
    o.imm26     = instr[6:31];
    o.storeData = b;
    o.busA      = c.lhiOp ? 32'(instr[16:31]) : a;
    if (c.rType) begin
        o.busB = b;
    end else if (c.lhiOp) begin
        o.busB = 32'd16;
    end else begin
        o.busB = imm;
    end
    o.destReg = c.rType ? instr[16:20] : instr[11:15];
    return o;
endfunction

function automatic dlxPkg::decoded_t expectDecoded(
    input dlxPkg::fetchItem_t item,
    input dlxPkg::writeback_t wbNow
);
    dlxPkg::decoded_t r;
    r.valid  = item.valid;
    r.nextPc = item.nextPc;
    r.ctrl   = expectCtrl(item.instruction);
    r.ops    = expectOps(item.instruction, r.ctrl,
                         shadowRead(item.instruction[6:10], wbNow),
                         shadowRead(item.instruction[11:15], wbNow));
    return r;
endfunction

`endif

// ==== tests/decodeStageTb.sv ====
module decodeStageTb;

    timeunit 1ns;
    timeprecision 1ps;

    // every test runs the same number of clock cycles
    localparam int numTests     = 6;
    localparam int itemsPerTest = 150;
    localparam int watchdogNs   = (numTests * itemsPerTest + 50) * 40;

    logic               clk;
    logic               rstN;
    dlxPkg::fetchItem_t fetch;
    logic               stall;
    logic               flush;
    dlxPkg::writeback_t wb;
    dlxPkg::decoded_t   decoded;

    // model pipeline, IF/ID contents and the expected ID/EX record
    dlxPkg::fetchItem_t modelIfId;
    dlxPkg::decoded_t   expDecoded;

    logic [15:0] lfsrState;
    logic [0:5]  allOps [0:20];
    logic [0:5]  fnList [0:9];
    int          totalChecks;
    int          totalErrors;

    `include "decodeModel.svh"

    decodeStage dut_i (
        .clk     (clk),
        .rstN    (rstN),
        .fetch   (fetch),
        .stall   (stall),
        .flush   (flush),
        .wb      (wb),
        .decoded (decoded)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus source
    //////////////////////////////////////////////////////////////////////

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = {1'b0, lfsrState[15:1]} ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
        end
        return value;
    endfunction

    // what the DUT does at this edge, using the inputs it sees now
    function automatic void modelEdge();
        dlxPkg::decoded_t fromIfId;
        fromIfId = expectDecoded(modelIfId, wb);
        // bubble into ID/EX on stall or flush
        if (stall || flush) begin
            expDecoded = '0;
        end else begin
            expDecoded = fromIfId;
        end
        // flush beats the load, stall holds
        if (flush) begin
            modelIfId = '0;
        end else if (!stall) begin
            modelIfId = fetch;
        end
        shadowWrite(wb);
    endfunction

    task automatic driveInputs(
        input int   lo,
        input int   count,
        input logic regFocus,
        input logic pipeFocus
    );
        dlxPkg::fetchItem_t item;
        dlxPkg::writeback_t wbNext;
        int                 idx;
        idx = lo + int'(takeBits(5)) % count;
        item.instruction       = takeBits(32);
        item.instruction[0:5]  = allOps[idx];
        if (allOps[idx] == dlxPkg::opRType) begin
            item.instruction[26:31] = fnList[int'(takeBits(4)) % 10];
        end
        if (regFocus) begin
            // few registers so reads hit r0 and the written one often
            item.instruction[6:10]  = 5'(takeBits(2));
            item.instruction[11:15] = 5'(takeBits(2));
        end
        item.nextPc = takeBits(32);
        item.valid  = pipeFocus ? (takeBits(2) != 0) : 1'b1;

        wbNext.enable = regFocus ? (takeBits(2) != 0) : (takeBits(1) != 0);
        wbNext.data   = takeBits(32);
        if (regFocus) begin
            // aim the write at a port that IF/ID reads next cycle
            case (takeBits(2))
                0:       wbNext.regIndex = modelIfId.instruction[6:10];
                1:       wbNext.regIndex = modelIfId.instruction[11:15];
                2:       wbNext.regIndex = '0;
                default: wbNext.regIndex = 5'(takeBits(5));
            endcase
        end else begin
            wbNext.regIndex = 5'(takeBits(5));
        end

        fetch <= item;
        wb    <= wbNext;
        stall <= pipeFocus && (takeBits(2) == 0);
        flush <= pipeFocus && (takeBits(3) == 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test runner
    //////////////////////////////////////////////////////////////////////

    // opcodes come from allOps[lo .. lo+count-1]
    task automatic runTest(
        input string name,
        input int    lo,
        input int    count,
        input logic  regFocus,
        input logic  pipeFocus
    );
        int testChecks;
        int testErrors;
        testChecks = 0;
        testErrors = 0;
        for (int i = 0; i < itemsPerTest; i++) begin
            @(posedge clk);
            modelEdge();
            driveInputs(lo, count, regFocus, pipeFocus);
            // outputs settled half a period after the edge
            @(negedge clk);
            testChecks++;
            if (decoded !== expDecoded) begin
                testErrors++;
                $display("MISMATCH %s expected %h actual %h", name, expDecoded, decoded);
            end
        end
        $display("test %-10s %0d checks, %0d errors", name, testChecks, testErrors);
        totalChecks += testChecks;
        totalErrors += testErrors;
    endtask

    initial begin
        rstN        = 1'b0;
        fetch       = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb          = '0;
        modelIfId   = '0;
        expDecoded  = '0;
        lfsrState   = 16'd62947;
        totalChecks = 0;
        totalErrors = 0;
        for (int i = 0; i < 32; i++) begin
            shadowRegs[i] = '0;
        end
        // grouped by class so a test can take a slice
        allOps = '{dlxPkg::opRType,
                   dlxPkg::opAddi, dlxPkg::opSubi, dlxPkg::opAndi, dlxPkg::opOri,
                   dlxPkg::opXori, dlxPkg::opLhi,
                   dlxPkg::opLb, dlxPkg::opLh, dlxPkg::opLw, dlxPkg::opLbu, dlxPkg::opLhu,
                   dlxPkg::opSb, dlxPkg::opSh, dlxPkg::opSw,
                   dlxPkg::opBeqz, dlxPkg::opBnez,
                   dlxPkg::opJ, dlxPkg::opJal, dlxPkg::opJr, dlxPkg::opJalr};
        fnList = '{dlxPkg::fnAdd, dlxPkg::fnSub, dlxPkg::fnAnd, dlxPkg::fnOr,
                   dlxPkg::fnXor, dlxPkg::fnSll, dlxPkg::fnSrl, dlxPkg::fnSra,
                   dlxPkg::fnSlt, dlxPkg::fnMul};

        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        totalChecks++;
        if (decoded !== '0) begin
            totalErrors++;
            $display("MISMATCH reset expected %h actual %h", dlxPkg::decoded_t'('0), decoded);
        end

        runTest("rtype", 0, 1, 1'b0, 1'b0);
        runTest("immediate", 1, 5, 1'b0, 1'b0);
        runTest("lhi", 6, 1, 1'b0, 1'b0);
        runTest("memflow", 7, 14, 1'b0, 1'b0);
        runTest("regfile", 0, 21, 1'b1, 1'b0);
        runTest("stallflush", 0, 21, 1'b0, 1'b1);

        $display("totals %0d tests, %0d checks, %0d errors", numTests, totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // hard stop in case the run stops making progress
    initial begin
        #(watchdogNs);
        $display("watchdog expired before the test sequence completed");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== source/decodeStage.sv ====
module decodeStage (
    input  logic                clk,
    input  logic                rstN,
    input  dlxPkg::fetchItem_t  fetch,
    input  logic                stall,
    input  logic                flush,
    input  dlxPkg::writeback_t  wb,
    output dlxPkg::decoded_t    decoded
);

    //////////////////////////////////////////////////////////////////////
    // stage wires
    //////////////////////////////////////////////////////////////////////

    dlxPkg::fetchItem_t      ifId;
    dlxPkg::ctrlWord_t       ctrl;
    dlxPkg::operands_t       ops;
    dlxPkg::decoded_t        idExD;
    logic [0:dlxPkg::xlen-1] rdA;
    logic [0:dlxPkg::xlen-1] rdB;

    // IF/ID holds during a stall, flush drops the held item
    stageRegister #(.payload_t(dlxPkg::fetchItem_t)) ifId_i (
        .clk   (clk),
        .rstN  (rstN),
        .load  (!stall),
        .clear (flush),
        .d     (fetch),
        .q     (ifId)
    );

    // rs1 in bits 6..10, rs2 in bits 11..15
    registerFile regFile_i (
        .clk  (clk),
        .rstN (rstN),
        .rs1  (ifId.instruction[6:10]),
        .rs2  (ifId.instruction[11:15]),
        .wb   (wb),
        .rdA  (rdA),
        .rdB  (rdB)
    );

    controlDecoder ctrlDec_i (
        .instruction (ifId.instruction),
        .ctrl        (ctrl)
    );

    operandSelect opSel_i (
        .instruction (ifId.instruction),
        .rdA         (rdA),
        .rdB         (rdB),
        .extOp       (ctrl.extOp),
        .lhiOp       (ctrl.lhiOp),
        .rType       (ctrl.rType),
        .ops         (ops)
    );

    // decoded record for execute
    assign idExD = '{valid: ifId.valid, nextPc: ifId.nextPc, ctrl: ctrl, ops: ops};

    // ID/EX takes a bubble whenever decode is held or flushed
    stageRegister #(.payload_t(dlxPkg::decoded_t)) idEx_i (
        .clk   (clk),
        .rstN  (rstN),
        .load  (1'b1),
        .clear (stall || flush),
        .d     (idExD),
        .q     (decoded)
    );

endmodule

// ==== source/operandSelect.sv ====
module operandSelect (
    input  logic [0:dlxPkg::xlen-1] instruction,
    input  logic [0:dlxPkg::xlen-1] rdA,
    input  logic [0:dlxPkg::xlen-1] rdB,
    input  logic                    extOp,
    input  logic                    lhiOp,
    input  logic                    rType,
    output dlxPkg::operands_t       ops
);

    //////////////////////////////////////////////////////////////////////
    // instruction fields
    //////////////////////////////////////////////////////////////////////

    logic [0:15]                  imm16;
    logic [0:25]                  imm26;
    logic [0:dlxPkg::regBits-1]   rs2;
    logic [0:dlxPkg::regBits-1]   rd;
    logic [0:dlxPkg::xlen-1]      immExt;
    logic [0:dlxPkg::xlen-1]      immZero;
    logic [0:dlxPkg::xlen-1]      busBImm;

    assign imm16 = instruction[16:31];
    assign imm26 = instruction[6:31];
    assign rs2   = instruction[11:15];
    // rd only exists in the R-type format
    assign rd    = instruction[16:20];

    //////////////////////////////////////////////////////////////////////
    // immediate extension
    //////////////////////////////////////////////////////////////////////

    // bit 0 is the sign bit of the immediate
    assign immZero = {16'h0000, imm16};
    assign immExt  = extOp ? {{16{imm16[0]}}, imm16} : immZero;

    // lhi shifts the immediate up by a fixed 16
    assign busBImm = lhiOp ? 32'd16 : immExt;

    //////////////////////////////////////////////////////////////////////
    // alu operands
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // register operand wins for R-type
        ops.busB = rType ? rdB : busBImm;

        // lhi feeds the raw immediate into the shifter
        ops.busA = lhiOp ? immZero : rdA;

        // stores always take their data from the second read port
        ops.storeData = rdB;

        ops.imm16 = imm16;
        ops.imm26 = imm26;

        // r31 for jal/jalr is picked at writeback, not here
        ops.destReg = rType ? rd : rs2;
    end

endmodule

// ==== source/controlDecoder.sv ====
module controlDecoder (
    input  logic [0:dlxPkg::xlen-1] instruction,
    output dlxPkg::ctrlWord_t       ctrl
);

    // opcode at the top, function field at the bottom
    logic [0:5] opcode;
    logic [0:5] func;

    assign opcode = instruction[0:5];
    assign func   = instruction[26:31];

    //////////////////////////////////////////////////////////////////////
    // main decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // unknown opcodes fall through with an empty word
        ctrl = '0;

        case (opcode)
            dlxPkg::opRType: begin
                ctrl.rType    = 1'b1;
                ctrl.regWrite = 1'b1;
                // alu op comes from the function field
                case (func)
                    dlxPkg::fnAdd: ctrl.aluCtrl = dlxPkg::aluAdd;
                    dlxPkg::fnSub: ctrl.aluCtrl = dlxPkg::aluSub;
                    dlxPkg::fnAnd: ctrl.aluCtrl = dlxPkg::aluAnd;
                    dlxPkg::fnOr:  ctrl.aluCtrl = dlxPkg::aluOr;
                    dlxPkg::fnXor: ctrl.aluCtrl = dlxPkg::aluXor;
                    dlxPkg::fnSll: ctrl.aluCtrl = dlxPkg::aluSll;
                    dlxPkg::fnSrl: ctrl.aluCtrl = dlxPkg::aluSrl;
                    dlxPkg::fnSra: ctrl.aluCtrl = dlxPkg::aluSra;
                    dlxPkg::fnSlt: ctrl.aluCtrl = dlxPkg::aluSlt;
                    dlxPkg::fnMul: begin
                        // multiplier does the work, alu just passes
                        ctrl.mul     = 1'b1;
                        ctrl.aluCtrl = dlxPkg::aluPass;
                    end
                    default: ctrl.aluCtrl = dlxPkg::aluAdd;
                endcase
            end

            // arithmetic immediates are signed
            dlxPkg::opAddi, dlxPkg::opSubi: begin
                ctrl.extOp    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = (opcode == dlxPkg::opSubi) ? dlxPkg::aluSub
                                                           : dlxPkg::aluAdd;
            end

            // logical immediates are zero extended
            dlxPkg::opAndi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = dlxPkg::aluAnd;
            end
            dlxPkg::opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = dlxPkg::aluOr;
            end
            dlxPkg::opXori: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = dlxPkg::aluXor;
            end

            // load high immediate as imm16 << 16
            dlxPkg::opLhi: begin
                ctrl.lhiOp    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = dlxPkg::aluSll;
            end

            ///////////////////////////////////////////////////////////////
            // memory access, address is base plus signed offset
            ///////////////////////////////////////////////////////////////

            dlxPkg::opLb, dlxPkg::opLh, dlxPkg::opLw, dlxPkg::opLbu, dlxPkg::opLhu: begin
                ctrl.extOp    = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                // unsigned variants skip sign fill
                ctrl.loadSign = (opcode != dlxPkg::opLbu) && (opcode != dlxPkg::opLhu);
                if (opcode == dlxPkg::opLw) begin
                    ctrl.dSize = dlxPkg::sizeWord;
                end else if (opcode == dlxPkg::opLh || opcode == dlxPkg::opLhu) begin
                    ctrl.dSize = dlxPkg::sizeHalf;
                end else begin
                    ctrl.dSize = dlxPkg::sizeByte;
                end
            end

            dlxPkg::opSb, dlxPkg::opSh, dlxPkg::opSw: begin
                ctrl.extOp    = 1'b1;
                ctrl.memWrite = 1'b1;
                if (opcode == dlxPkg::opSw) begin
                    ctrl.dSize = dlxPkg::sizeWord;
                end else if (opcode == dlxPkg::opSh) begin
                    ctrl.dSize = dlxPkg::sizeHalf;
                end else begin
                    ctrl.dSize = dlxPkg::sizeByte;
                end
            end

            ///////////////////////////////////////////////////////////////
            // control flow
            ///////////////////////////////////////////////////////////////

            // branch offset is signed, beqz also tests for zero
            dlxPkg::opBeqz, dlxPkg::opBnez: begin
                ctrl.extOp      = 1'b1;
                ctrl.branch     = 1'b1;
                ctrl.branchZero = (opcode == dlxPkg::opBeqz);
            end

            // pc relative jumps with the 26 bit offset
            dlxPkg::opJ: ctrl.jump = 1'b1;
            dlxPkg::opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.pcToReg  = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            // register target jumps
            dlxPkg::opJr: ctrl.regToPc = 1'b1;
            dlxPkg::opJalr: begin
                ctrl.regToPc  = 1'b1;
                ctrl.pcToReg  = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            default: ctrl = '0;
        endcase
    end

    // exclusive flags the execute and memory stages rely on
    always_comb begin
        assert (!(ctrl.jump && ctrl.branch))
            else $error("jump and branch both set");
        assert (!(ctrl.memWrite && ctrl.regWrite))
            else $error("memWrite and regWrite both set");
    end

endmodule

// ==== source/registerFile.sv ====
module registerFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [0:dlxPkg::regBits-1]  rs1,
    input  logic [0:dlxPkg::regBits-1]  rs2,
    input  dlxPkg::writeback_t          wb,
    output logic [0:dlxPkg::xlen-1]     rdA,
    output logic [0:dlxPkg::xlen-1]     rdB
);

    // r0 has no storage and always reads as zero
    logic [0:dlxPkg::xlen-1] regs [1:31];

    // one read port with write-through from the writeback bus
    function automatic logic [0:dlxPkg::xlen-1] readPort(
        input logic [0:dlxPkg::regBits-1] idx
    );
        logic [0:dlxPkg::xlen-1] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb.enable && wb.regIndex == idx) begin
            // same cycle write is seen by the read
            value = wb.data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    // reads follow the array and the writeback bus as well as the index
    always_comb begin
        rdA = readPort(rs1);
        rdB = readPort(rs2);
    end

    // write at the clock edge and drop writes to r0
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && wb.regIndex != '0) begin
            regs[wb.regIndex] <= wb.data;
        end
    end

    // the writeback stage must name a real register when it writes
    wbIndexKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        wb.enable |-> !$isunknown(wb.regIndex)
    ) else $error("writeback index unknown while enable is high");

endmodule

// ==== source/stageRegister.sv ====
module stageRegister #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     load,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // payload width, valid sits in the top bit
    localparam int width = $bits(payload_t);

    // flat view of the stored record for the valid check
    logic [width-1:0] qBits;

    //////////////////////////////////////////////////////////////////////
    // pipeline register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;
        end else if (clear) begin
            // clear beats load, leaves a bubble
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

    assign qBits = q;

    // valid must stay known once out of reset or downstream stages
    // would act on a phantom item
    validKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        !$isunknown(qBits[width-1])
    ) else $error("stage register valid bit is unknown");

endmodule

// ==== source/dlxPkg.sv ====
package dlxPkg;

    //////////////////////////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////////////////////////

    localparam int xlen    = 32;
    localparam int regBits = 5;

    //////////////////////////////////////////////////////////////////////
    // opcodes, instruction bits 0..5
    //////////////////////////////////////////////////////////////////////

    localparam logic [0:5] opRType = 6'h00;
    localparam logic [0:5] opJ     = 6'h02;
    localparam logic [0:5] opJal   = 6'h03;
    localparam logic [0:5] opBeqz  = 6'h04;
    localparam logic [0:5] opBnez  = 6'h05;
    localparam logic [0:5] opAddi  = 6'h08;
    localparam logic [0:5] opSubi  = 6'h0A;
    localparam logic [0:5] opAndi  = 6'h0C;
    localparam logic [0:5] opOri   = 6'h0D;
    localparam logic [0:5] opXori  = 6'h0E;
    localparam logic [0:5] opLhi   = 6'h0F;
    localparam logic [0:5] opJr    = 6'h12;
    localparam logic [0:5] opJalr  = 6'h13;
    localparam logic [0:5] opLb    = 6'h20;
    localparam logic [0:5] opLh    = 6'h21;
    localparam logic [0:5] opLw    = 6'h23;
    localparam logic [0:5] opLbu   = 6'h24;
    localparam logic [0:5] opLhu   = 6'h25;
    localparam logic [0:5] opSb    = 6'h28;
    localparam logic [0:5] opSh    = 6'h29;
    localparam logic [0:5] opSw    = 6'h2B;

    // function codes, instruction bits 26..31 of an R-type word
    localparam logic [0:5] fnSll = 6'h04;
    localparam logic [0:5] fnSrl = 6'h06;
    localparam logic [0:5] fnSra = 6'h07;
    localparam logic [0:5] fnMul = 6'h0E;
    localparam logic [0:5] fnAdd = 6'h20;
    localparam logic [0:5] fnSub = 6'h22;
    localparam logic [0:5] fnAnd = 6'h24;
    localparam logic [0:5] fnOr  = 6'h25;
    localparam logic [0:5] fnXor = 6'h26;
    localparam logic [0:5] fnSlt = 6'h2A;

    // alu operation select, zero is add so an empty word is harmless
    localparam logic [0:3] aluAdd  = 4'd0;
    localparam logic [0:3] aluSub  = 4'd1;
    localparam logic [0:3] aluAnd  = 4'd2;
    localparam logic [0:3] aluOr   = 4'd3;
    localparam logic [0:3] aluXor  = 4'd4;
    localparam logic [0:3] aluSll  = 4'd5;
    localparam logic [0:3] aluSrl  = 4'd6;
    localparam logic [0:3] aluSra  = 4'd7;
    localparam logic [0:3] aluSlt  = 4'd8;
    localparam logic [0:3] aluPass = 4'd9;

    // memory access size
    localparam logic [0:1] sizeByte = 2'd0;
    localparam logic [0:1] sizeHalf = 2'd1;
    localparam logic [0:1] sizeWord = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // records passed between blocks, first field is the msb
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [0:xlen-1] nextPc;
        logic [0:xlen-1] instruction;
    } fetchItem_t;

    typedef struct packed {
        logic       pcToReg;
        logic       regToPc;
        logic       jump;
        logic       branch;
        logic       branchZero;
        logic       rType;
        logic       regWrite;
        logic       memToReg;
        logic       memWrite;
        logic       loadSign;
        logic       mul;
        logic       extOp;
        logic       lhiOp;
        logic [0:1] dSize;
        logic [0:3] aluCtrl;
    } ctrlWord_t;

    typedef struct packed {
        logic [0:xlen-1]    busA;
        logic [0:xlen-1]    busB;
        logic [0:xlen-1]    storeData;
        logic [0:15]        imm16;
        logic [0:25]        imm26;
        logic [0:regBits-1] destReg;
    } operands_t;

    typedef struct packed {
        logic            valid;
        logic [0:xlen-1] nextPc;
        ctrlWord_t       ctrl;
        operands_t       ops;
    } decoded_t;

    typedef struct packed {
        logic               enable;
        logic [0:regBits-1] regIndex;
        logic [0:xlen-1]    data;
    } writeback_t;

endpackage
